/* source/uart_pkg.sv */
package uart_pkg;

  localparam int AXI_ADDR_W = 13;
  localparam int AXI_DATA_W = 32;

  // Master-driven half of the AXI-Lite bus
  typedef struct packed {
    logic                  aw_valid;
    logic [AXI_ADDR_W-1:0] aw_addr;
    logic                  w_valid;
    logic [AXI_DATA_W-1:0] w_data;
    logic                  b_ready;
    logic                  ar_valid;
    logic [AXI_ADDR_W-1:0] ar_addr;
    logic                  r_ready;
  } axi_lite_req_t;

  // Slave-driven half
  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    logic [1:0]            b_resp;
    logic                  ar_ready;
    logic                  r_valid;
    logic [AXI_DATA_W-1:0] r_data;
    logic [1:0]            r_resp;
  } axi_lite_resp_t;

  // Single-cycle access into the register window
  typedef struct packed {
    logic       valid;
    logic       write;
    logic [3:0] offset;
    logic [7:0] wdata;
    logic       err;
  } reg_access_t;

  // Receive FIFO payload
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;
  } rx_entry_t;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam logic [3:0] REG_RX   = 4'h0;
  localparam logic [3:0] REG_TX   = 4'h4;
  localparam logic [3:0] REG_STAT = 4'h8;
  localparam logic [3:0] REG_CTRL = 4'hC;

  localparam int ST_RX_VALID  = 0;
  localparam int ST_RX_FULL   = 1;
  localparam int ST_TX_EMPTY  = 2;
  localparam int ST_TX_FULL   = 3;
  localparam int ST_INTR_EN   = 4;
  localparam int ST_OVERRUN   = 5;
  localparam int ST_FRAME_ERR = 6;

  localparam int CTRL_RST_TX  = 0;
  localparam int CTRL_RST_RX  = 1;
  localparam int CTRL_INTR_EN = 4;

endpackage

/* source/uart_fifo.sv */
`timescale 1ns/1ps

module uart_fifo #(
  parameter int  Depth   = 16,
  parameter type entry_t = logic [7:0]
) (
  input  logic   clk_i,
  input  logic   rstn_i,
  input  logic   clr_i,
  input  logic   push_i,
  input  entry_t data_i,
  input  logic   pop_i,
  output entry_t data_o,
  output logic   empty_o,
  output logic   full_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  entry_t          mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push_ok, pop_ok;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntW'(Depth));
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  // First-word fall-through
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i || clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int ClksPerBit = 868
) (
  input  logic       clk_i,
  input  logic       rstn_i,
  input  logic       valid_i,
  input  logic [7:0] data_i,
  output logic       ready_o,
  output logic       tx_o
);

  localparam int CntW = $clog2(ClksPerBit + 1);

  logic            busy_q;
  logic [CntW-1:0] cnt_q;
  logic [3:0]      bit_q;
  logic [9:0]      shift_q;
  logic            bit_done;
  logic            start;

  assign ready_o  = !busy_q;
  assign start    = valid_i && ready_o;
  assign bit_done = (cnt_q == CntW'(ClksPerBit - 1));

  // Line idles high between frames
  assign tx_o = busy_q ? shift_q[0] : 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      bit_q  <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
      bit_q  <= '0;
    end else if (busy_q) begin
      if (bit_done) begin
        cnt_q <= '0;
        // Ten bits: start, eight data, stop
        if (bit_q == 4'd9) begin
          busy_q <= 1'b0;
        end else begin
          bit_q <= bit_q + 1'b1;
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Frame shifts out LSB first
  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_q <= {1'b1, data_i, 1'b0};
    end else if (busy_q && bit_done) begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
  parameter int ClksPerBit = 868
) (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      rx_i,
  output logic      valid_o,
  output rx_entry_t entry_o
);

  localparam int CntW    = $clog2(ClksPerBit + 1);
  localparam int HalfBit = ClksPerBit / 2;

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } state_e;

  state_e          state_q;
  logic            rx_meta_q, rx_sync_q, rx_prev_q;
  logic [CntW-1:0] cnt_q;
  logic [2:0]      bit_q;
  logic [7:0]      shift_q;
  logic            valid_q;
  rx_entry_t       entry_q;
  logic            bit_done;

  assign bit_done = (cnt_q == CntW'(ClksPerBit - 1));
  assign valid_o  = valid_q;
  assign entry_o  = entry_q;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
      state_q   <= S_IDLE;
      cnt_q     <= '0;
      bit_q     <= '0;
      valid_q   <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
      valid_q   <= 1'b0;
      case (state_q)
        S_IDLE: begin
          // Falling edge marks a possible start bit
          if (rx_prev_q && !rx_sync_q) begin
            state_q <= S_START;
            cnt_q   <= '0;
          end
        end
        S_START: begin
          if (cnt_q == CntW'(HalfBit - 1)) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            // Glitch if the line is back high at mid-bit
            state_q <= rx_sync_q ? S_IDLE : S_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        S_DATA: begin
          if (bit_done) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= S_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        S_STOP: begin
          if (bit_done) begin
            cnt_q   <= '0;
            valid_q <= 1'b1;
            state_q <= S_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Data arrives LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == S_DATA && bit_done) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
    if (state_q == S_STOP && bit_done) begin
      entry_q.data      <= shift_q;
      entry_q.frame_err <= !rx_sync_q;
    end
  end

endmodule

/* source/uart_axi_slave.sv */
`timescale 1ns/1ps

module uart_axi_slave import uart_pkg::*; #(
  parameter logic [AXI_ADDR_W-1:0] BaseAddr = 13'h1000
) (
  input  logic           clk_i,
  input  logic           rstn_i,
  input  axi_lite_req_t  axi_req_i,
  output axi_lite_resp_t axi_resp_o,
  output reg_access_t    acc_o,
  input  logic [7:0]     rdata_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WR_ACC,
    S_WR_RESP,
    S_RD_ACC,
    S_RD_RESP
  } state_e;

  state_e                state_q, state_d;
  logic [AXI_ADDR_W-1:0] addr;
  logic [AXI_ADDR_W-1:0] offset;
  logic                  in_window;
  logic                  accept;
  logic [1:0]            b_resp_q;
  logic [1:0]            r_resp_q;
  logic [AXI_DATA_W-1:0] r_data_q;

  // One transaction at a time, write wins a tie
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (axi_req_i.aw_valid && axi_req_i.w_valid) begin
          state_d = S_WR_ACC;
        end else if (axi_req_i.ar_valid) begin
          state_d = S_RD_ACC;
        end
      end
      S_WR_ACC:  state_d = S_WR_RESP;
      S_WR_RESP: if (axi_req_i.b_ready) state_d = S_IDLE;
      S_RD_ACC:  state_d = S_RD_RESP;
      S_RD_RESP: if (axi_req_i.r_ready) state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Offset decode for the accepted address
  assign addr      = (state_q == S_WR_ACC) ? axi_req_i.aw_addr : axi_req_i.ar_addr;
  assign offset    = addr - BaseAddr;
  assign in_window = (addr >= BaseAddr) && (offset < AXI_ADDR_W'(16));
  assign accept    = (state_q == S_WR_ACC) || (state_q == S_RD_ACC);

  always_comb begin
    acc_o        = '0;
    acc_o.valid  = accept && in_window;
    acc_o.write  = (state_q == S_WR_ACC);
    acc_o.offset = offset[3:0];
    acc_o.wdata  = axi_req_i.w_data[7:0];
    acc_o.err    = accept && !in_window;
  end

  // Response payload, held while the master stalls
  always_ff @(posedge clk_i) begin
    if (state_q == S_WR_ACC) begin
      b_resp_q <= in_window ? RESP_OKAY : RESP_SLVERR;
    end
    if (state_q == S_RD_ACC) begin
      r_resp_q <= in_window ? RESP_OKAY : RESP_SLVERR;
      r_data_q <= in_window ? AXI_DATA_W'(rdata_i) : '0;
    end
  end

  always_comb begin
    axi_resp_o          = '0;
    axi_resp_o.aw_ready = (state_q == S_WR_ACC);
    axi_resp_o.w_ready  = (state_q == S_WR_ACC);
    axi_resp_o.b_valid  = (state_q == S_WR_RESP);
    axi_resp_o.b_resp   = b_resp_q;
    axi_resp_o.ar_ready = (state_q == S_RD_ACC);
    axi_resp_o.r_valid  = (state_q == S_RD_RESP);
    axi_resp_o.r_data   = r_data_q;
    axi_resp_o.r_resp   = r_resp_q;
  end

endmodule

/* source/uart_reg_map.sv */
`timescale 1ns/1ps

module uart_reg_map import uart_pkg::*; (
  input  logic        clk_i,
  input  logic        rstn_i,
  input  reg_access_t acc_i,
  output logic [7:0]  rdata_o,
  output logic        tx_push_o,
  output logic [7:0]  tx_data_o,
  input  logic        tx_full_i,
  input  logic        tx_empty_i,
  output logic        tx_clr_o,
  output logic        rx_pop_o,
  input  rx_entry_t   rx_entry_i,
  input  logic        rx_empty_i,
  input  logic        rx_full_i,
  output logic        rx_clr_o,
  input  logic        rx_valid_i,
  output logic        irq_o
);

  logic       rd, wr;
  logic       stat_rd, ctrl_wr;
  logic       intr_en_q;
  logic       overrun_q;
  logic       frame_err_q;
  logic [7:0] status;

  assign rd      = acc_i.valid && !acc_i.write;
  assign wr      = acc_i.valid && acc_i.write;
  assign stat_rd = rd && (acc_i.offset == REG_STAT);
  assign ctrl_wr = wr && (acc_i.offset == REG_CTRL);

  // FIFO strobes
  assign tx_push_o = wr && (acc_i.offset == REG_TX) && !tx_full_i;
  assign tx_data_o = acc_i.wdata;
  assign rx_pop_o  = rd && (acc_i.offset == REG_RX) && !rx_empty_i;
  assign tx_clr_o  = ctrl_wr && acc_i.wdata[CTRL_RST_TX];
  assign rx_clr_o  = ctrl_wr && acc_i.wdata[CTRL_RST_RX];

  always_comb begin
    status               = '0;
    status[ST_RX_VALID]  = !rx_empty_i;
    status[ST_RX_FULL]   = rx_full_i;
    status[ST_TX_EMPTY]  = tx_empty_i;
    status[ST_TX_FULL]   = tx_full_i;
    status[ST_INTR_EN]   = intr_en_q;
    status[ST_OVERRUN]   = overrun_q;
    status[ST_FRAME_ERR] = frame_err_q;
  end

  always_comb begin
    case (acc_i.offset)
      REG_RX:   rdata_o = rx_empty_i ? 8'h00 : rx_entry_i.data;
      REG_STAT: rdata_o = status;
      default:  rdata_o = 8'h00;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      intr_en_q   <= 1'b0;
      overrun_q   <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        intr_en_q <= acc_i.wdata[CTRL_INTR_EN];
      end
      // Status read clears, a new event in the same cycle wins
      if (stat_rd) begin
        overrun_q   <= 1'b0;
        frame_err_q <= 1'b0;
      end
      if (rx_valid_i && rx_full_i) begin
        overrun_q <= 1'b1;
      end
      if (rx_pop_o && rx_entry_i.frame_err) begin
        frame_err_q <= 1'b1;
      end
    end
  end

  assign irq_o = intr_en_q && (!rx_empty_i || tx_empty_i);

endmodule

/* source/uart_lite_top.sv */
`timescale 1ns/1ps

module uart_lite_top import uart_pkg::*; #(
  parameter logic [AXI_ADDR_W-1:0] BaseAddr   = 13'h1000,
  parameter int                    ClksPerBit = 868,
  parameter int                    FifoDepth  = 16
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic [AXI_ADDR_W-1:0] s_axi_awaddr_i,
  input  logic                  s_axi_awvalid_i,
  output logic                  s_axi_awready_o,
  input  logic [AXI_DATA_W-1:0] s_axi_wdata_i,
  input  logic                  s_axi_wvalid_i,
  output logic                  s_axi_wready_o,
  output logic [1:0]            s_axi_bresp_o,
  output logic                  s_axi_bvalid_o,
  input  logic                  s_axi_bready_i,
  input  logic [AXI_ADDR_W-1:0] s_axi_araddr_i,
  input  logic                  s_axi_arvalid_i,
  output logic                  s_axi_arready_o,
  output logic [AXI_DATA_W-1:0] s_axi_rdata_o,
  output logic [1:0]            s_axi_rresp_o,
  output logic                  s_axi_rvalid_o,
  input  logic                  s_axi_rready_i,
  input  logic                  rx_i,
  output logic                  tx_o,
  output logic                  irq_o
);

  axi_lite_req_t  axi_req;
  axi_lite_resp_t axi_resp;
  reg_access_t    acc;
  logic [7:0]     rdata;
  logic           tx_push, tx_full, tx_empty, tx_clr, tx_pop, tx_valid, tx_ready;
  logic [7:0]     tx_data, tx_byte;
  logic           rx_pop, rx_empty, rx_full, rx_clr, rx_valid;
  rx_entry_t      rx_entry, rx_head;

  // Flat bus into structs
  assign axi_req.aw_valid = s_axi_awvalid_i;
  assign axi_req.aw_addr  = s_axi_awaddr_i;
  assign axi_req.w_valid  = s_axi_wvalid_i;
  assign axi_req.w_data   = s_axi_wdata_i;
  assign axi_req.b_ready  = s_axi_bready_i;
  assign axi_req.ar_valid = s_axi_arvalid_i;
  assign axi_req.ar_addr  = s_axi_araddr_i;
  assign axi_req.r_ready  = s_axi_rready_i;

  assign s_axi_awready_o = axi_resp.aw_ready;
  assign s_axi_wready_o  = axi_resp.w_ready;
  assign s_axi_bvalid_o  = axi_resp.b_valid;
  assign s_axi_bresp_o   = axi_resp.b_resp;
  assign s_axi_arready_o = axi_resp.ar_ready;
  assign s_axi_rvalid_o  = axi_resp.r_valid;
  assign s_axi_rdata_o   = axi_resp.r_data;
  assign s_axi_rresp_o   = axi_resp.r_resp;

  // Shifter takes the FIFO head when idle
  assign tx_valid = !tx_empty;
  assign tx_pop   = tx_valid && tx_ready;

  uart_axi_slave #(
    .BaseAddr (BaseAddr)
  ) i_axi_slave (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .axi_req_i  (axi_req),
    .axi_resp_o (axi_resp),
    .acc_o      (acc),
    .rdata_i    (rdata)
  );

  uart_reg_map i_reg_map (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .acc_i      (acc),
    .rdata_o    (rdata),
    .tx_push_o  (tx_push),
    .tx_data_o  (tx_data),
    .tx_full_i  (tx_full),
    .tx_empty_i (tx_empty),
    .tx_clr_o   (tx_clr),
    .rx_pop_o   (rx_pop),
    .rx_entry_i (rx_head),
    .rx_empty_i (rx_empty),
    .rx_full_i  (rx_full),
    .rx_clr_o   (rx_clr),
    .rx_valid_i (rx_valid),
    .irq_o      (irq_o)
  );

  uart_fifo #(
    .Depth   (FifoDepth),
    .entry_t (logic [7:0])
  ) i_tx_fifo (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .clr_i   (tx_clr),
    .push_i  (tx_push),
    .data_i  (tx_data),
    .pop_i   (tx_pop),
    .data_o  (tx_byte),
    .empty_o (tx_empty),
    .full_o  (tx_full)
  );

  uart_fifo #(
    .Depth   (FifoDepth),
    .entry_t (rx_entry_t)
  ) i_rx_fifo (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .clr_i   (rx_clr),
    .push_i  (rx_valid),
    .data_i  (rx_entry),
    .pop_i   (rx_pop),
    .data_o  (rx_head),
    .empty_o (rx_empty),
    .full_o  (rx_full)
  );

  uart_tx #(
    .ClksPerBit (ClksPerBit)
  ) i_tx (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .valid_i (tx_valid),
    .data_i  (tx_byte),
    .ready_o (tx_ready),
    .tx_o    (tx_o)
  );

  uart_rx #(
    .ClksPerBit (ClksPerBit)
  ) i_rx (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .rx_i    (rx_i),
    .valid_o (rx_valid),
    .entry_o (rx_entry)
  );

endmodule

/* verif/uart_lite_assert.sv */
`timescale 1ns/1ps

module uart_lite_assert (
  input logic        clk_i,
  input logic        rstn_i,
  input logic        awvalid_i,
  input logic        wvalid_i,
  input logic        awready_i,
  input logic        wready_i,
  input logic        bvalid_i,
  input logic        bready_i,
  input logic [1:0]  bresp_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic [31:0] rdata_i,
  input logic [1:0]  rresp_i,
  input logic        tx_idle_i,
  input logic        tx_i
);

  int fail_cnt = 0;

  // Responses hold until the master takes them
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      $error("write response dropped or changed under back-pressure");
      fail_cnt++;
    end

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      $error("read response dropped or changed under back-pressure");
      fail_cnt++;
    end

  // One joint ready pulse on the cycle after both valids
  a_aw_w: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (awready_i || wready_i) |->
      awready_i && wready_i && $past(awvalid_i && wvalid_i) && !$past(awready_i))
    else begin
      $error("awready and wready not a single joint pulse after both valids");
      fail_cnt++;
    end

  // The stop bit leaves the line high when the shifter goes idle
  a_tx_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    tx_idle_i |-> tx_i && (!$rose(tx_idle_i) || $past(tx_i)))
    else begin
      $error("tx line low while the shifter is idle");
      fail_cnt++;
    end

endmodule

bind uart_lite_top uart_lite_assert i_assert (
  .clk_i     (clk_i),
  .rstn_i    (rstn_i),
  .awvalid_i (s_axi_awvalid_i),
  .wvalid_i  (s_axi_wvalid_i),
  .awready_i (s_axi_awready_o),
  .wready_i  (s_axi_wready_o),
  .bvalid_i  (s_axi_bvalid_o),
  .bready_i  (s_axi_bready_i),
  .bresp_i   (s_axi_bresp_o),
  .rvalid_i  (s_axi_rvalid_o),
  .rready_i  (s_axi_rready_i),
  .rdata_i   (s_axi_rdata_o),
  .rresp_i   (s_axi_rresp_o),
  .tx_idle_i (tx_ready),
  .tx_i      (tx_o)
);

/* verif/uart_lite_tb.sv */
`timescale 1ns/1ps

module uart_lite_tb import uart_pkg::*; ();

  localparam logic [12:0] Base = 13'h1000;
  localparam int Depth     = 4;
  localparam int Bit       = 8;
  localparam int NumFrames = 40;
  localparam int Timeout   = NumFrames * 12 * Bit + 2000;

  logic        clk = 1'b0, rstn;
  logic [12:0] awaddr, araddr;
  logic        awvalid, wvalid, bready, arvalid, rready, rx;
  logic [31:0] wdata, rdata;
  logic        awready, wready, bvalid, arready, rvalid, tx, irq;
  logic [1:0]  bresp, rresp;

  int   errors = 0;
  logic [8:0] rx_q[$];
  logic [7:0] tx_exp[$], tx_got[$];
  logic exp_en = 0, exp_ovr = 0, exp_ferr = 0;

  uart_lite_top #(.BaseAddr(Base), .ClksPerBit(Bit), .FifoDepth(Depth)) i_dut (
    .clk_i(clk), .rstn_i(rstn),
    .s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
    .s_axi_wdata_i(wdata), .s_axi_wvalid_i(wvalid), .s_axi_wready_o(wready),
    .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid), .s_axi_bready_i(bready),
    .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready),
    .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp), .s_axi_rvalid_o(rvalid),
    .s_axi_rready_i(rready), .rx_i(rx), .tx_o(tx), .irq_o(irq)
  );

  always #10 clk = ~clk;

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic axi_write(input logic [12:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    awvalid = 1;
    wvalid = 1;
    do @(negedge clk); while (!awready);
    expect_eq(wready, 1, "wready with awready");
    @(negedge clk);
    awvalid = 0;
    wvalid = 0;
    // Response is due one cycle after the accept
    expect_eq(bvalid, 1, "bvalid after accept");
    repeat ($urandom_range(0, 3)) @(negedge clk);
    expect_eq(bvalid, 1, "bvalid under stall");
    resp = bresp;
    bready = 1;
    @(negedge clk);
    bready = 0;
    expect_eq(bvalid, 0, "bvalid after handshake");
  endtask

  task automatic axi_read(input logic [12:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge clk);
    araddr = addr;
    arvalid = 1;
    do @(negedge clk); while (!arready);
    @(negedge clk);
    arvalid = 0;
    expect_eq(rvalid, 1, "rvalid after accept");
    repeat ($urandom_range(0, 3)) @(negedge clk);
    expect_eq(rvalid, 1, "rvalid under stall");
    data = rdata;
    resp = rresp;
    rready = 1;
    @(negedge clk);
    rready = 0;
    expect_eq(rvalid, 0, "rvalid after handshake");
  endtask

  task automatic write_ok(input logic [3:0] off, input logic [7:0] data);
    logic [1:0] resp;
    axi_write(Base + off, {24'h0, data}, resp);
    expect_eq(resp, RESP_OKAY, "bresp");
  endtask

  // Status read against the model clears the sticky bits
  task automatic check_status(input logic tx_empty, input logic tx_full);
    logic [31:0] d;
    logic [1:0]  resp;
    logic [7:0]  exp;
    axi_read(Base + REG_STAT, d, resp);
    exp = {1'b0, exp_ferr, exp_ovr, exp_en, tx_full, tx_empty,
           rx_q.size() == Depth, rx_q.size() != 0};
    expect_eq(d, {24'h0, exp}, "status");
    expect_eq(resp, RESP_OKAY, "status rresp");
    exp_ovr = 0;
    exp_ferr = 0;
  endtask

  task automatic read_rx_check();
    logic [31:0] d;
    logic [1:0]  resp;
    logic [8:0]  e;
    e = '0;
    if (rx_q.size() != 0) begin
      e = rx_q.pop_front();
      if (e[0]) exp_ferr = 1;
    end
    axi_read(Base + REG_RX, d, resp);
    expect_eq(d, {24'h0, e[8:1]}, "rx data");
    expect_eq(resp, RESP_OKAY, "rx rresp");
  endtask

  task automatic check_irq(input logic tx_empty);
    @(negedge clk);
    expect_eq(irq, exp_en && (rx_q.size() != 0 || tx_empty), "irq");
  endtask

  // Serial driver that waits until the frame lands in the RX FIFO
  task automatic send_frame(input logic [7:0] d, input logic stop);
    @(negedge clk);
    rx = 0;
    repeat (Bit) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = d[i];
      repeat (Bit) @(negedge clk);
    end
    rx = stop;
    repeat (Bit) @(negedge clk);
    rx = 1;
    repeat (3 * Bit) @(negedge clk);
    if (rx_q.size() == Depth) exp_ovr = 1;
    else rx_q.push_back({d, !stop});
  endtask

  task automatic drain_tx();
    int cnt;
    cnt = 0;
    while (tx_got.size() < tx_exp.size() && cnt < 12 * Bit * (Depth + 2)) begin
      @(negedge clk);
      cnt++;
    end
    repeat (2 * Bit) @(negedge clk);
    expect_eq(tx_got.size(), tx_exp.size(), "tx frame count");
    while (tx_exp.size() != 0 && tx_got.size() != 0)
      expect_eq(tx_got.pop_front(), tx_exp.pop_front(), "tx byte");
    tx_exp.delete();
    tx_got.delete();
  endtask

  // Serial monitor sampling each bit near its middle
  initial begin
    logic [7:0] b;
    @(posedge rstn);
    forever begin
      @(negedge clk);
      if (!tx) begin
        repeat (Bit / 2 - 1) @(negedge clk);
        if (tx) begin
          errors++;
          $display("tx start bit did not hold low at %0t", $time);
        end
        for (int i = 0; i < 8; i++) begin
          repeat (Bit) @(negedge clk);
          b[i] = tx;
        end
        repeat (Bit) @(negedge clk);
        if (!tx) begin
          errors++;
          $display("tx stop bit low at %0t", $time);
        end
        tx_got.push_back(b);
      end
    end
  end

  initial begin
    repeat (Timeout) @(posedge clk);
    $display("timeout after %0d cycles, the run did not finish", Timeout);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic [31:0] d;
    logic [1:0]  resp;
    int          n;
    logic [7:0]  b;
    void'($urandom(45));
    rstn = 0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    awvalid = 0;
    wvalid = 0;
    bready = 0;
    arvalid = 0;
    rready = 0;
    rx = 1;
    repeat (3) @(negedge clk);
    rstn = 1;
    expect_eq({awready, wready, arready, bvalid, rvalid}, 5'b0, "handshakes after reset");
    expect_eq(tx, 1, "tx line after reset");
    check_irq(1);

    // TX bursts fill the shifter and the FIFO and drop the rest
    for (int r = 0; r < 3; r++) begin
      n = (r == 0) ? Depth + 2 : $urandom_range(1, Depth + 2);
      for (int i = 0; i < n; i++) begin
        b = $urandom_range(0, 255);
        write_ok(REG_TX, b);
        if (i <= Depth) tx_exp.push_back(b);
      end
      if (r == 0) check_status(0, 1);
      drain_tx();
    end
    check_status(1, 0);

    // RX frames read back in order and one empty read
    for (int i = 0; i < 3; i++) send_frame($urandom_range(0, 255), 1);
    check_status(1, 0);
    for (int i = 0; i < 4; i++) read_rx_check();
    check_status(1, 0);

    // Framing error and overrun
    send_frame($urandom_range(0, 255), 0);
    read_rx_check();
    check_status(1, 0);
    check_status(1, 0);
    for (int i = 0; i < Depth + 1; i++) send_frame($urandom_range(0, 255), 1);
    check_status(1, 0);
    check_status(1, 0);
    read_rx_check();

    // Control register, FIFO resets and interrupt
    write_ok(REG_CTRL, 8'h10);
    exp_en = 1;
    check_irq(1);
    write_ok(REG_CTRL, 8'h12);
    rx_q.delete();
    check_status(1, 0);
    check_irq(1);
    send_frame($urandom_range(0, 255), 1);
    b = $urandom_range(0, 255);
    write_ok(REG_TX, b);
    tx_exp.push_back(b);
    write_ok(REG_TX, 8'hA5);
    write_ok(REG_TX, 8'h5A);
    check_irq(0);
    // RX cleared while TX still holds bytes
    write_ok(REG_CTRL, 8'h12);
    rx_q.delete();
    check_irq(0);
    write_ok(REG_CTRL, 8'h13);
    rx_q.delete();
    check_irq(1);
    check_status(1, 0);
    write_ok(REG_CTRL, 8'h00);
    exp_en = 0;
    check_irq(1);
    drain_tx();

    // Unmapped offsets and read-only registers
    axi_write(Base + 13'h10, 32'h0, resp);
    expect_eq(resp, RESP_SLVERR, "bresp at 0x10");
    axi_read(Base + 13'h14, d, resp);
    expect_eq(resp, RESP_SLVERR, "rresp at 0x14");
    expect_eq(d, 0, "rdata at 0x14");
    axi_write(Base - 13'h4, 32'h0, resp);
    expect_eq(resp, RESP_SLVERR, "bresp below window");
    write_ok(REG_RX, 8'h55);
    write_ok(REG_STAT, 8'hFF);
    axi_read(Base + REG_TX, d, resp);
    expect_eq(d, 0, "tx register read");
    expect_eq(resp, RESP_OKAY, "tx register rresp");
    axi_read(Base + REG_CTRL, d, resp);
    expect_eq(d, 0, "ctrl register read");
    expect_eq(resp, RESP_OKAY, "ctrl register rresp");
    check_status(1, 0);
    repeat (4 * Bit) @(negedge clk);
    expect_eq(tx_got.size(), 0, "unexpected tx frames");

    errors += i_dut.i_assert.fail_cnt;
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_axi_slave.sv
source/uart_reg_map.sv
source/uart_lite_top.sv
verif/uart_lite_assert.sv
verif/uart_lite_tb.sv

/* Bender.yml */
package:
  name: uart_lite

sources:
  - source/uart_pkg.sv
  - source/uart_fifo.sv
  - source/uart_tx.sv
  - source/uart_rx.sv
  - source/uart_axi_slave.sv
  - source/uart_reg_map.sv
  - source/uart_lite_top.sv
  - target: test
    files:
      - verif/uart_lite_assert.sv
      - verif/uart_lite_tb.sv
